// File: Bender.yml
package:
  name: trc

sources:
  - include_dirs:
      - include
    files:
      - verilog/trc_pkg.sv
      - verilog/trc_decode.sv
      - verilog/trc_execute.sv
      - verilog/trc_result.sv
      - verilog/trc_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/trc_tb_clock.sv
      - sim/trc_tb.sv

// File: list.f
+incdir+include
verilog/trc_pkg.sv
verilog/trc_decode.sv
verilog/trc_execute.sv
verilog/trc_result.sv
verilog/trc_top.sv
sim/trc_tb_clock.sv
sim/trc_tb.sv

// File: sim/trc_tb.sv
`timescale 1ns/10ps
`include "trc_defines.svh"

module trc_tb;

   localparam int MAX_ROWS       = 40;
   localparam int TIMEOUT_CYCLES = 200;
   localparam int IDLE_CYCLES    = 20;
   localparam int PKT_W          = `TRC_RING_W;

   // rv64 major opcodes used by the table
   localparam logic [6:0] OP     = 7'h33;
   localparam logic [6:0] OP_IMM = 7'h13;
   localparam logic [6:0] LUI    = 7'h37;
   localparam logic [6:0] JAL    = 7'h6F;
   localparam logic [6:0] JALR   = 7'h67;
   localparam logic [6:0] LOAD   = 7'h03;
   localparam logic [6:0] STORE  = 7'h23;
   localparam logic [6:0] SYSTEM = 7'h73;

   // operand patterns shared by the load and store rows
   localparam logic [63:0] LD_DATA = 64'h0123_4567_89AB_CDEF;
   localparam logic [63:0] ST_DATA = 64'hFEDC_BA98_7654_3210;
   localparam logic [63:0] BASE    = 64'h1000;

   logic                 clk, reset;
   logic                 instr_req, instr_ack, miss, roll, poison;
   logic [31:0]          instr;
   logic [`TRC_XLEN-1:0] pc, rs1, rs2, load_data;
   logic                 trace_req, trace_ack;
   logic [PKT_W-1:0]     trace_data;
   logic                 mon_done;
   integer               seed = 32'h903c_a725;

   // stimulus table and the packets it should produce, in order
   string            row_name  [MAX_ROWS];
   logic [31:0]      row_instr [MAX_ROWS];
   logic [63:0]      row_pc    [MAX_ROWS];
   logic [63:0]      row_rs1   [MAX_ROWS];
   logic [63:0]      row_rs2   [MAX_ROWS];
   logic [63:0]      row_load  [MAX_ROWS];
   logic [2:0]       row_flags [MAX_ROWS];
   int               row_count = 0;
   string            exp_name  [MAX_ROWS];
   logic [PKT_W-1:0] exp_pkt   [MAX_ROWS];
   int               exp_count = 0;

   trc_tb_clock trc_tb_clock_inst (.clk_o(clk), .reset_o(reset));

   trc_top trc_top_inst (
      .clk_i(clk), .reset_i(reset), .instr_req_i(instr_req), .instr_ack_o(instr_ack),
      .instr_i(instr), .pc_i(pc), .rs1_i(rs1), .rs2_i(rs2), .load_data_i(load_data),
      .miss_i(miss), .roll_i(roll), .poison_i(poison), .trace_req_o(trace_req),
      .trace_ack_i(trace_ack), .trace_data_o(trace_data)
   );

   // register fields are fixed, operands come from the table
   function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd);
      return {f7, 5'd2, 5'd1, f3, rd, OP};
   endfunction

   function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
      return {imm, 5'd1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [2:0] f3);
      return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], STORE};
   endfunction

   function automatic logic [PKT_W-1:0] reg_pkt(input logic [4:0] rd, input logic [63:0] value);
      return {1'b0, 59'b0, rd, value};
   endfunction

   function automatic logic [PKT_W-1:0] store_pkt(input logic [63:0] addr,
                                                  input logic [63:0] data);
      return {1'b1, addr, data};
   endfunction

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Testbench failed");
      $fatal(1, "simulation stopped at %0t", $time);
   endtask

   task automatic check_value(input string name, input logic [PKT_W-1:0] expected,
                              input logic [PKT_W-1:0] actual);
      if (actual !== expected) begin
         report_failure($sformatf("** Error %s: expected %h, actual %h", name, expected,
                                  actual));
      end
   endtask

   task automatic add_row(input string name, input logic [31:0] code, input logic [63:0] pc_v,
                          input logic [63:0] a, input logic [63:0] b, input logic [63:0] ld,
                          input logic [2:0] flags, input logic has_pkt,
                          input logic [PKT_W-1:0] pkt);
      row_name[row_count]  = name;
      row_instr[row_count] = code;
      row_pc[row_count]    = pc_v;
      row_rs1[row_count]   = a;
      row_rs2[row_count]   = b;
      row_load[row_count]  = ld;
      row_flags[row_count] = flags;
      row_count++;
      if (has_pkt) begin
         exp_name[exp_count] = name;
         exp_pkt[exp_count]  = pkt;
         exp_count++;
      end
   endtask

   task automatic wait_reset_release();
      int cycles;
      cycles = 0;
      while (reset !== 1'b0) begin
         @(posedge clk);
         cycles++;
         if (cycles > TIMEOUT_CYCLES) report_failure("reset was never released");
      end
   endtask

   task automatic wait_ack(input logic level, input string name, output int cycles);
      cycles = 0;
      while (instr_ack !== level) begin
         @(posedge clk);
         cycles++;
         if (cycles > TIMEOUT_CYCLES) begin
            report_failure($sformatf("intake acknowledge stuck at %b during %s", ~level, name));
         end
      end
   endtask

   // one four-phase intake transfer, returns the edges spent waiting for the ack
   task automatic send_row(input int idx, output int ack_cycles);
      int drop_cycles;
      instr_req <= 1'b1;
      instr     <= row_instr[idx];
      pc        <= row_pc[idx];
      rs1       <= row_rs1[idx];
      rs2       <= row_rs2[idx];
      load_data <= row_load[idx];
      {miss, roll, poison} <= row_flags[idx];
      wait_ack(1'b1, row_name[idx], ack_cycles);
      instr_req <= 1'b0;
      wait_ack(1'b0, row_name[idx], drop_cycles);
   endtask

   initial begin : main
      int cycles;
      int i;
      instr_req = 1'b0;
      instr     = '0;
      pc        = '0;
      rs1       = '0;
      rs2       = '0;
      load_data = LD_DATA;
      miss      = 1'b0;
      roll      = 1'b0;
      poison    = 1'b0;
      trace_ack = 1'b0;
      mon_done  = 1'b0;

      add_row("add", r_type(7'h00, 3'd0, 5'd5), 0, 64'h10, 64'h20, 0, 0, 1,
              reg_pkt(5'd5, 64'h30));
      add_row("sub", r_type(7'h20, 3'd0, 5'd6), 0, 64'd5, 64'd7, 0, 0, 1,
              reg_pkt(5'd6, 64'hFFFF_FFFF_FFFF_FFFE));
      add_row("and", r_type(7'h00, 3'd7, 5'd7), 0, 64'hF0F0, 64'hFF00, 0, 0, 1,
              reg_pkt(5'd7, 64'hF000));
      add_row("or", r_type(7'h00, 3'd6, 5'd8), 0, 64'hF0F0, 64'h0F0F, 0, 0, 1,
              reg_pkt(5'd8, 64'hFFFF));
      add_row("xor", r_type(7'h00, 3'd4, 5'd9), 0, 64'hFF, 64'h0F, 0, 0, 1,
              reg_pkt(5'd9, 64'hF0));
      add_row("sll", r_type(7'h00, 3'd1, 5'd10), 0, 64'h1, 64'd4, 0, 0, 1,
              reg_pkt(5'd10, 64'h10));
      add_row("srl", r_type(7'h00, 3'd5, 5'd11), 0, 64'h8000_0000_0000_0000, 64'd63, 0, 0, 1,
              reg_pkt(5'd11, 64'h1));
      add_row("slt", r_type(7'h00, 3'd2, 5'd12), 0, 64'hFFFF_FFFF_FFFF_FFFF, 64'h1, 0, 0, 1,
              reg_pkt(5'd12, 64'h1));
      add_row("add x0", r_type(7'h00, 3'd0, 5'd0), 0, 64'h1, 64'h2, 0, 0, 0, '0);
      add_row("addi", i_type(12'hFFF, 3'd0, 5'd13, OP_IMM), 0, 64'h100, 0, 0, 0, 1,
              reg_pkt(5'd13, 64'hFF));
      add_row("slli", i_type(12'h008, 3'd1, 5'd14, OP_IMM), 0, 64'h1, 0, 0, 0, 1,
              reg_pkt(5'd14, 64'h100));
      add_row("lui", {20'h80000, 5'd15, LUI}, 0, 0, 0, 0, 0, 1,
              reg_pkt(5'd15, 64'hFFFF_FFFF_8000_0000));
      add_row("lb miss", i_type(12'h0, 3'd0, 5'd16, LOAD), 0, BASE, 0, LD_DATA, 3'b100, 0, '0);
      // each signed load sets only the sign bit of its own size
      add_row("lb", i_type(12'h0, 3'd0, 5'd16, LOAD), 0, BASE, 0, 64'h0123_4567_0101_0180,
              0, 1, reg_pkt(5'd16, 64'hFFFF_FFFF_FFFF_FF80));
      add_row("lb pos", i_type(12'h0, 3'd0, 5'd26, LOAD), 0, BASE, 0, 64'hFFFF_FFFF_FFFF_FF7F,
              0, 1, reg_pkt(5'd26, 64'h7F));
      add_row("lh", i_type(12'h0, 3'd1, 5'd17, LOAD), 0, BASE, 0, 64'h0123_4567_0000_8070,
              0, 1, reg_pkt(5'd17, 64'hFFFF_FFFF_FFFF_8070));
      add_row("lw", i_type(12'h0, 3'd2, 5'd18, LOAD), 0, BASE, 0, 64'h0123_4567_8000_7F70,
              0, 1, reg_pkt(5'd18, 64'hFFFF_FFFF_8000_7F70));
      add_row("ld", i_type(12'h0, 3'd3, 5'd19, LOAD), 0, BASE, 0, LD_DATA, 0, 1,
              reg_pkt(5'd19, 64'h0123_4567_89AB_CDEF));
      add_row("lbu", i_type(12'h0, 3'd4, 5'd20, LOAD), 0, BASE, 0, LD_DATA, 0, 1,
              reg_pkt(5'd20, 64'hEF));
      add_row("lhu", i_type(12'h0, 3'd5, 5'd21, LOAD), 0, BASE, 0, LD_DATA, 0, 1,
              reg_pkt(5'd21, 64'hCDEF));
      add_row("lwu", i_type(12'h0, 3'd6, 5'd22, LOAD), 0, BASE, 0, LD_DATA, 0, 1,
              reg_pkt(5'd22, 64'h89AB_CDEF));
      add_row("sb", s_type(12'h010, 3'd0), 0, BASE, ST_DATA, 0, 0, 1,
              store_pkt(64'h1010, 64'h10));
      add_row("sh", s_type(12'hFFC, 3'd1), 0, BASE, ST_DATA, 0, 0, 1,
              store_pkt(64'h0FFC, 64'h3210));
      add_row("sw", s_type(12'h020, 3'd2), 0, BASE, ST_DATA, 0, 0, 1,
              store_pkt(64'h1020, 64'h7654_3210));
      add_row("sd", s_type(12'h008, 3'd3), 0, BASE, ST_DATA, 0, 0, 1,
              store_pkt(64'h1008, 64'hFEDC_BA98_7654_3210));
      add_row("sb roll", s_type(12'h010, 3'd0), 0, BASE, ST_DATA, 0, 3'b010, 0, '0);
      add_row("jal", {20'h00100, 5'd1, JAL}, 64'h8000_0000, 0, 0, 0, 0, 1,
              reg_pkt(5'd1, 64'h8000_0004));
      add_row("jalr", i_type(12'h010, 3'd0, 5'd2, JALR), 64'h8000_0100, BASE, 0, 0, 0, 1,
              reg_pkt(5'd2, 64'h8000_0104));
      add_row("add poison", r_type(7'h00, 3'd0, 5'd5), 0, 64'h1, 64'h2, 0, 3'b001, 0, '0);
      add_row("mhartid", i_type(`TRC_CSR_MHARTID, 3'd2, 5'd23, SYSTEM), 0, 0, 0, 0, 0, 1,
              reg_pkt(5'd23, `TRC_HART_ID));
      add_row("mstatus", i_type(12'h300, 3'd2, 5'd24, SYSTEM), 0, 0, 0, 0, 0, 0, '0);
      add_row("unknown", 32'hFFFF_FFFF, 0, 0, 0, 0, 0, 0, '0);
      add_row("add last", r_type(7'h00, 3'd0, 5'd25), 0, 64'h1, 64'h2, 0, 0, 1,
              reg_pkt(5'd25, 64'h3));

      wait_reset_release();
      for (i = 0; i < row_count; i++) begin
         send_row(i, cycles);
         // first ack only after the boot wait has run out
         if (i == 0) check_value("boot wait", 1, cycles > `TRC_BOOT_CYCLES);
      end

      cycles = 0;
      while (mon_done !== 1'b1) begin
         @(posedge clk);
         cycles++;
         if (cycles > TIMEOUT_CYCLES) report_failure("expected trace packets never arrived");
      end
      for (i = 0; i < IDLE_CYCLES; i++) begin
         @(posedge clk);
         if (trace_req !== 1'b0) report_failure("extra trace request after the last packet");
      end
      $display("Testbench passed");
      $finish;
   end

   // trace side, answers each request after a random delay
   initial begin : monitor
      int k;
      int cycles;
      int delay;
      wait_reset_release();
      for (k = 0; k < exp_count; k++) begin
         cycles = 0;
         while (trace_req !== 1'b1) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
               report_failure($sformatf("no trace request for %s", exp_name[k]));
            end
         end
         delay = $unsigned($random(seed)) % 6;
         repeat (delay) @(posedge clk);
         check_value(exp_name[k], exp_pkt[k], trace_data);
         trace_ack <= 1'b1;
         cycles = 0;
         while (trace_req !== 1'b0) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) report_failure("trace request never dropped");
         end
         trace_ack <= 1'b0;
      end
      mon_done = 1'b1;
   end

endmodule : trc_tb

// File: sim/trc_tb_clock.sv
`timescale 1ns/10ps

module trc_tb_clock #(
   parameter int HALF_PERIOD  = 20,
   parameter int RESET_CYCLES = 8
) (
   output logic clk_o,
   output logic reset_o
);

   initial begin
      clk_o = 1'b0;
      forever #HALF_PERIOD clk_o = ~clk_o;
   end

   // reset released on a rising edge, seen by the DUT one edge later
   initial begin
      reset_o = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_o);
      reset_o <= 1'b0;
   end

endmodule : trc_tb_clock

// File: verilog/trc_top.sv
`timescale 1ns/10ps
`include "trc_defines.svh"

module trc_top
   import trc_pkg::*;
(
   input  logic                   clk_i,
   input  logic                   reset_i,
   input  logic                   instr_req_i,
   output logic                   instr_ack_o,
   input  logic [31:0]            instr_i,
   input  logic [`TRC_XLEN-1:0]   pc_i,
   input  logic [`TRC_XLEN-1:0]   rs1_i,
   input  logic [`TRC_XLEN-1:0]   rs2_i,
   input  logic [`TRC_XLEN-1:0]   load_data_i,
   input  logic                   miss_i,
   input  logic                   roll_i,
   input  logic                   poison_i,
   output logic                   trace_req_o,
   input  logic                   trace_ack_i,
   output logic [`TRC_RING_W-1:0] trace_data_o
);

   // stage 1, decode to execute
   logic                 d_valid, d_unsigned, d_flags_ok;
   trc_class_e           d_class;
   trc_alu_e             d_alu;
   trc_size_e            d_size;
   logic [4:0]           d_rd;
   logic [`TRC_XLEN-1:0] d_imm, d_pc, d_rs1, d_rs2, d_load;

   // stage 2, execute to result
   logic                 e_valid, e_flags_ok, e_stall, r_stall;
   trc_class_e           e_class;
   logic [4:0]           e_rd;
   logic [`TRC_XLEN-1:0] e_value, e_addr;

   trc_decode trc_decode_inst (
      .clk_i, .reset_i, .instr_req_i, .instr_ack_o, .instr_i, .pc_i, .rs1_i, .rs2_i,
      .load_data_i, .miss_i, .roll_i, .poison_i, .e_stall_i(e_stall),
      .d_valid_o(d_valid), .d_class_o(d_class), .d_alu_o(d_alu), .d_size_o(d_size),
      .d_unsigned_o(d_unsigned), .d_rd_o(d_rd), .d_imm_o(d_imm), .d_pc_o(d_pc),
      .d_rs1_o(d_rs1), .d_rs2_o(d_rs2), .d_load_o(d_load), .d_flags_ok_o(d_flags_ok)
   );

   trc_execute trc_execute_inst (
      .clk_i, .reset_i, .d_valid_i(d_valid), .d_class_i(d_class), .d_alu_i(d_alu),
      .d_size_i(d_size), .d_unsigned_i(d_unsigned), .d_rd_i(d_rd), .d_imm_i(d_imm),
      .d_pc_i(d_pc), .d_rs1_i(d_rs1), .d_rs2_i(d_rs2), .d_load_i(d_load),
      .d_flags_ok_i(d_flags_ok), .r_stall_i(r_stall), .e_stall_o(e_stall),
      .e_valid_o(e_valid), .e_class_o(e_class), .e_rd_o(e_rd), .e_value_o(e_value),
      .e_addr_o(e_addr), .e_flags_ok_o(e_flags_ok)
   );

   trc_result trc_result_inst (
      .clk_i, .reset_i, .e_valid_i(e_valid), .e_class_i(e_class), .e_rd_i(e_rd),
      .e_value_i(e_value), .e_addr_i(e_addr), .e_flags_ok_i(e_flags_ok),
      .r_stall_o(r_stall), .trace_req_o, .trace_ack_i, .trace_data_o
   );

endmodule : trc_top

// File: verilog/trc_result.sv
`timescale 1ns/10ps
`include "trc_defines.svh"

module trc_result
   import trc_pkg::*;
(
   input  logic                   clk_i,
   input  logic                   reset_i,
   input  logic                   e_valid_i,
   input  trc_class_e             e_class_i,
   input  logic [4:0]             e_rd_i,
   input  logic [`TRC_XLEN-1:0]   e_value_i,
   input  logic [`TRC_XLEN-1:0]   e_addr_i,
   input  logic                   e_flags_ok_i,
   output logic                   r_stall_o,
   output logic                   trace_req_o,
   input  logic                   trace_ack_i,
   output logic [`TRC_RING_W-1:0] trace_data_o
);

   logic                   keep;
   logic                   busy;
   logic                   take;
   logic                   ack_wait;
   logic [`TRC_RING_W-1:0] packet;

   // drop on any exception, unknown encodings and writes to x0
   always_comb begin
      keep = e_flags_ok_i && (e_class_i != CLS_NONE);
      if (e_class_i != CLS_STORE && e_rd_i == 5'd0) keep = 1'b0;
   end

   always_comb begin
      if (e_class_i == CLS_STORE) begin
         packet = {1'b1, e_addr_i, e_value_i};
      end else begin
         packet = {1'b0, 59'b0, e_rd_i, e_value_i};
      end
   end

   // busy while a request is out or the ack has not dropped yet
   assign busy = trace_req_o | (ack_wait & trace_ack_i);

   // dropped entries pass even while the output is busy
   assign r_stall_o = e_valid_i & keep & busy;

   assign take = e_valid_i & keep & ~busy;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         trace_req_o <= 1'b0;
         ack_wait    <= 1'b0;
      end else if (take) begin
         trace_req_o <= 1'b1;
         ack_wait    <= 1'b0;
      end else if (trace_req_o && trace_ack_i) begin
         trace_req_o <= 1'b0;
         ack_wait    <= 1'b1;
      end else if (ack_wait && !trace_ack_i) begin
         ack_wait <= 1'b0;
      end
   end

   // packet register, held for the whole handshake
   always_ff @(posedge clk_i) begin
      if (take) begin
         trace_data_o <= packet;
      end
   end

   data_stable: assert property (@(posedge clk_i) disable iff (reset_i)
      trace_req_o && $past(trace_req_o) |-> $stable(trace_data_o));

endmodule : trc_result

// File: verilog/trc_execute.sv
`timescale 1ns/10ps
`include "trc_defines.svh"

module trc_execute
   import trc_pkg::*;
(
   input  logic                 clk_i,
   input  logic                 reset_i,
   input  logic                 d_valid_i,
   input  trc_class_e           d_class_i,
   input  trc_alu_e             d_alu_i,
   input  trc_size_e            d_size_i,
   input  logic                 d_unsigned_i,
   input  logic [4:0]           d_rd_i,
   input  logic [`TRC_XLEN-1:0] d_imm_i,
   input  logic [`TRC_XLEN-1:0] d_pc_i,
   input  logic [`TRC_XLEN-1:0] d_rs1_i,
   input  logic [`TRC_XLEN-1:0] d_rs2_i,
   input  logic [`TRC_XLEN-1:0] d_load_i,
   input  logic                 d_flags_ok_i,
   input  logic                 r_stall_i,
   output logic                 e_stall_o,
   output logic                 e_valid_o,
   output trc_class_e           e_class_o,
   output logic [4:0]           e_rd_o,
   output logic [`TRC_XLEN-1:0] e_value_o,
   output logic [`TRC_XLEN-1:0] e_addr_o,
   output logic                 e_flags_ok_o
);

   logic [`TRC_XLEN-1:0] alu_res;
   logic [`TRC_XLEN-1:0] load_ext;
   logic [`TRC_XLEN-1:0] store_data;
   logic [`TRC_XLEN-1:0] value;

   // stage 2 is stuck only while it holds something result cannot take
   assign e_stall_o = e_valid_o & r_stall_i;

   always_comb begin
      case (d_alu_i)
         ALU_ADD:    alu_res = d_rs1_i + d_imm_i;
         ALU_SUB:    alu_res = d_rs1_i - d_imm_i;
         ALU_AND:    alu_res = d_rs1_i & d_imm_i;
         ALU_OR:     alu_res = d_rs1_i | d_imm_i;
         ALU_XOR:    alu_res = d_rs1_i ^ d_imm_i;
         ALU_SLL:    alu_res = d_rs1_i << d_imm_i[5:0];
         ALU_SRL:    alu_res = d_rs1_i >> d_imm_i[5:0];
         ALU_SLT:    alu_res = {63'b0, $signed(d_rs1_i) < $signed(d_imm_i)};
         ALU_PASS_B: alu_res = d_imm_i;
         default:    alu_res = '0;
      endcase
   end

   // load result extended by size, store data zero-extended
   always_comb begin
      case (d_size_i)
         SZ_B: begin
            load_ext   = {{56{d_load_i[7] & ~d_unsigned_i}}, d_load_i[7:0]};
            store_data = {56'b0, d_rs2_i[7:0]};
         end
         SZ_H: begin
            load_ext   = {{48{d_load_i[15] & ~d_unsigned_i}}, d_load_i[15:0]};
            store_data = {48'b0, d_rs2_i[15:0]};
         end
         SZ_W: begin
            load_ext   = {{32{d_load_i[31] & ~d_unsigned_i}}, d_load_i[31:0]};
            store_data = {32'b0, d_rs2_i[31:0]};
         end
         default: begin
            load_ext   = d_load_i;
            store_data = d_rs2_i;
         end
      endcase
   end

   always_comb begin
      case (d_class_i)
         CLS_INT:    value = alu_res;
         CLS_LOAD:   value = load_ext;
         CLS_STORE:  value = store_data;
         CLS_JUMP:   value = d_pc_i + 64'd4;
         CLS_HARTID: value = `TRC_HART_ID;
         default:    value = '0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         e_valid_o <= 1'b0;
      end else if (!e_stall_o) begin
         e_valid_o <= d_valid_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!e_stall_o) begin
         e_class_o    <= d_class_i;
         e_rd_o       <= d_rd_i;
         e_value_o    <= value;
         e_addr_o     <= d_rs1_i + d_imm_i;
         e_flags_ok_o <= d_flags_ok_i;
      end
   end

   class_known: assert property (@(posedge clk_i) disable iff (reset_i)
      e_valid_o |-> !$isunknown(e_class_o));

endmodule : trc_execute

// File: verilog/trc_decode.sv
`timescale 1ns/10ps
`include "trc_defines.svh"

module trc_decode
   import trc_pkg::*;
(
   input  logic                 clk_i,
   input  logic                 reset_i,
   input  logic                 instr_req_i,
   output logic                 instr_ack_o,
   input  logic [31:0]          instr_i,
   input  logic [`TRC_XLEN-1:0] pc_i,
   input  logic [`TRC_XLEN-1:0] rs1_i,
   input  logic [`TRC_XLEN-1:0] rs2_i,
   input  logic [`TRC_XLEN-1:0] load_data_i,
   input  logic                 miss_i,
   input  logic                 roll_i,
   input  logic                 poison_i,
   input  logic                 e_stall_i,
   output logic                 d_valid_o,
   output trc_class_e           d_class_o,
   output trc_alu_e             d_alu_o,
   output trc_size_e            d_size_o,
   output logic                 d_unsigned_o,
   output logic [4:0]           d_rd_o,
   output logic [`TRC_XLEN-1:0] d_imm_o,
   output logic [`TRC_XLEN-1:0] d_pc_o,
   output logic [`TRC_XLEN-1:0] d_rs1_o,
   output logic [`TRC_XLEN-1:0] d_rs2_o,
   output logic [`TRC_XLEN-1:0] d_load_o,
   output logic                 d_flags_ok_o
);

   localparam int BOOT_W = $clog2(`TRC_BOOT_CYCLES + 1);

   logic [BOOT_W-1:0]    boot_cnt;
   logic                 boot_done;
   logic                 capture;
   logic [6:0]           opcode;
   logic [2:0]           funct3;
   logic [6:0]           funct7;
   logic                 f3_ok;
   trc_alu_e             alu_f3;
   trc_class_e           dec_class;
   trc_alu_e             dec_alu;
   logic [`TRC_XLEN-1:0] dec_imm;
   logic [`TRC_XLEN-1:0] imm_i;
   logic [`TRC_XLEN-1:0] imm_s;
   logic [`TRC_XLEN-1:0] imm_u;
   logic [`TRC_XLEN-1:0] imm_j;

   assign boot_done = (boot_cnt == BOOT_W'(`TRC_BOOT_CYCLES));

   // take a new instruction only once stage 1 is free or moving on
   assign capture = instr_req_i & ~instr_ack_o & boot_done & (~d_valid_o | ~e_stall_i);

   assign opcode = instr_i[6:0];
   assign funct3 = instr_i[14:12];
   assign funct7 = instr_i[31:25];

   assign imm_i = {{52{instr_i[31]}}, instr_i[31:20]};
   assign imm_s = {{52{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
   assign imm_u = {{32{instr_i[31]}}, instr_i[31:12], 12'b0};
   assign imm_j = {{43{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                   instr_i[30:21], 1'b0};

   // funct3 table shared by op and op-imm, sltu is not supported
   always_comb begin
      f3_ok = 1'b1;
      case (funct3)
         3'b000:  alu_f3 = ALU_ADD;
         3'b001:  alu_f3 = ALU_SLL;
         3'b010:  alu_f3 = ALU_SLT;
         3'b100:  alu_f3 = ALU_XOR;
         3'b101:  alu_f3 = ALU_SRL;
         3'b110:  alu_f3 = ALU_OR;
         3'b111:  alu_f3 = ALU_AND;
         default: begin
            alu_f3 = ALU_ADD;
            f3_ok  = 1'b0;
         end
      endcase
   end

   always_comb begin
      dec_class = CLS_NONE;
      dec_alu   = alu_f3;
      dec_imm   = imm_i;
      case (opcode)
         OPC_OP: begin
            // register ops carry rs2 in the operand b slot
            dec_imm = rs2_i;
            if (f3_ok && funct7 == 7'b0) begin
               dec_class = CLS_INT;
            end else if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
               dec_class = CLS_INT;
               dec_alu   = ALU_SUB;
            end
         end
         OPC_OP_IMM: begin
            // rv64 shifts have a 6-bit shamt, upper bits must be zero
            if (f3_ok && (funct3[1:0] != 2'b01 || instr_i[31:26] == 6'b0)) begin
               dec_class = CLS_INT;
            end
         end
         OPC_LUI: begin
            dec_class = CLS_INT;
            dec_alu   = ALU_PASS_B;
            dec_imm   = imm_u;
         end
         OPC_JAL: begin
            dec_class = CLS_JUMP;
            dec_imm   = imm_j;
         end
         OPC_JALR: begin
            if (funct3 == 3'b000) dec_class = CLS_JUMP;
         end
         OPC_LOAD: begin
            if (funct3 != 3'b111) dec_class = CLS_LOAD;
         end
         OPC_STORE: begin
            dec_imm = imm_s;
            if (!funct3[2]) dec_class = CLS_STORE;
         end
         OPC_SYSTEM: begin
            if (funct3 == F3_CSRRS && instr_i[31:20] == `TRC_CSR_MHARTID) begin
               dec_class = CLS_HARTID;
            end
         end
         default: dec_class = CLS_NONE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         boot_cnt    <= '0;
         instr_ack_o <= 1'b0;
         d_valid_o   <= 1'b0;
      end else begin
         if (!boot_done) boot_cnt <= boot_cnt + 1'b1;
         if (capture) begin
            instr_ack_o <= 1'b1;
            d_valid_o   <= 1'b1;
         end else begin
            if (instr_ack_o && !instr_req_i) instr_ack_o <= 1'b0;
            if (!e_stall_i) d_valid_o <= 1'b0;
         end
      end
   end

   // stage 1 payload
   always_ff @(posedge clk_i) begin
      if (capture) begin
         d_class_o    <= dec_class;
         d_alu_o      <= dec_alu;
         d_size_o     <= trc_size_e'(funct3[1:0]);
         d_unsigned_o <= funct3[2];
         d_rd_o       <= instr_i[11:7];
         d_imm_o      <= dec_imm;
         d_pc_o       <= pc_i;
         d_rs1_o      <= rs1_i;
         d_rs2_o      <= rs2_i;
         d_load_o     <= load_data_i;
         d_flags_ok_o <= ~(miss_i | roll_i | poison_i);
      end
   end

   // acknowledge only answers a request that is still held
   ack_follows_req: assert property (@(posedge clk_i) disable iff (reset_i)
      $rose(instr_ack_o) |-> $past(instr_req_i) && instr_req_i);

endmodule : trc_decode

// File: verilog/trc_pkg.sv
package trc_pkg;

   // instruction class as seen by the trace
   typedef enum logic [2:0] {
      CLS_NONE   = 3'd0,
      CLS_INT    = 3'd1,
      CLS_LOAD   = 3'd2,
      CLS_STORE  = 3'd3,
      CLS_JUMP   = 3'd4,
      CLS_HARTID = 3'd5
   } trc_class_e;

   // integer operation, pass_b serves lui
   typedef enum logic [3:0] {
      ALU_ADD    = 4'd0,
      ALU_SUB    = 4'd1,
      ALU_AND    = 4'd2,
      ALU_OR     = 4'd3,
      ALU_XOR    = 4'd4,
      ALU_SLL    = 4'd5,
      ALU_SRL    = 4'd6,
      ALU_SLT    = 4'd7,
      ALU_PASS_B = 4'd8
   } trc_alu_e;

   // memory access size, matches funct3[1:0] of loads and stores
   typedef enum logic [1:0] {
      SZ_B = 2'd0,
      SZ_H = 2'd1,
      SZ_W = 2'd2,
      SZ_D = 2'd3
   } trc_size_e;

   // rv64 major opcodes handled by decode
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;
   localparam logic [6:0] OPC_JALR   = 7'b1100111;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;
   localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

   // funct3 of csrrs
   localparam logic [2:0] F3_CSRRS = 3'b010;

endpackage : trc_pkg

// File: include/trc_defines.svh
`ifndef TRC_DEFINES_SVH
`define TRC_DEFINES_SVH

// data and address width of the core
`define TRC_XLEN 64

// trace ring packet width, flag bit plus two 64-bit fields
`define TRC_RING_W 129

// value returned by a read of mhartid
`define TRC_HART_ID 64'h0

// idle cycles after reset before intake opens
`define TRC_BOOT_CYCLES 3

// csr number of mhartid
`define TRC_CSR_MHARTID 12'hF14

`endif
